/* logic/hal_cfg_pkg.sv */
// Host command codes and configuration register widths for the HPS port
package hal_cfg_pkg;

	////////////////////////////////////////////////////////////
	// Host word and command
	////////////////////////////////////////////////////////////

	// Data word carried by one req/ack handshake
	typedef logic [15:0] io_word_t;

	// Command byte, low half of the first word in a frame
	typedef logic [7:0] cmd_t;

	// LED override, mask in the high byte and state in the low byte
	localparam cmd_t CMD_LED = 8'h25;
	// Volume attenuation, bits 4..0 of the data word
	localparam cmd_t CMD_VOL = 8'h26;

	////////////////////////////////////////////////////////////
	// Register payloads
	////////////////////////////////////////////////////////////

	typedef logic [7:0] led_t;

	// Bit 4 mutes, bits 3..0 are an arithmetic right shift
	typedef logic [4:0] vol_att_t;

endpackage

/* logic/hal_audio_pkg.sv */
// Audio sample types, mixer modes and paired audio and sync bundles
package hal_audio_pkg;

	// One channel sample as seen on the core and Linux sides
	typedef logic [15:0] sample_t;

	// Internal sum with one bit of headroom
	typedef logic signed [16:0] acc_t;

	// Cross-feed between left and right
	typedef enum logic [1:0] {
		MIX_NONE,
		MIX_25,
		MIX_50,
		MIX_MONO
	} mix_mode_t;

	typedef struct packed {
		sample_t l;
		sample_t r;
	} audio_pair_t;

	typedef struct packed {
		logic hs;
		logic vs;
	} sync_pair_t;

endpackage

/* logic/hps_io_regs.sv */
// HPS req/ack command port with LED override and volume registers
`timescale 1ns/1ns

module hps_io_regs (
	input  logic                   clk_sys,
	input  logic                   resetd,
	input  logic                   i_io_req,
	input  logic                   i_io_uio,
	input  hal_cfg_pkg::io_word_t  i_io_din,
	output logic                   o_io_ack,
	input  hal_cfg_pkg::led_t      i_led_status,
	output hal_cfg_pkg::led_t      o_led,
	output hal_cfg_pkg::vol_att_t  o_vol_att
);

	import hal_cfg_pkg::*;

	// Command byte taken or not in the current frame
	typedef enum logic {
		IDLE,
		DATA
	} state_t;

	state_t state;
	logic   rack;
	logic   io_strobe;
	logic   cmd_take;
	cmd_t   cmd;
	led_t   led_mask;
	led_t   led_state;

	////////////////////////////////////////////////////////////
	// Handshake
	////////////////////////////////////////////////////////////

	// One cycle pulse when the first req stage rises
	assign io_strobe = rack & ~o_io_ack;

	// First word of an open frame carries the command
	assign cmd_take = i_io_uio & io_strobe & (state == IDLE);

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			rack      <= 1'b0;
			o_io_ack  <= 1'b0;
			state     <= IDLE;
			led_mask  <= '0;
			led_state <= '0;
			o_vol_att <= '0;
		end else begin
			rack     <= i_io_req;
			o_io_ack <= rack;

			if (!i_io_uio) begin
				state <= IDLE;
			end else if (io_strobe) begin
				if (state == IDLE) begin
					state <= DATA;
				end else begin
					case (cmd)
						CMD_LED: begin
							led_mask  <= i_io_din[15:8];
							led_state <= i_io_din[7:0];
						end
						CMD_VOL: o_vol_att <= i_io_din[4:0];
						// Data of other commands is dropped
						default: ;
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cmd_take) begin
			cmd <= i_io_din[7:0];
		end
	end

	////////////////////////////////////////////////////////////
	// LED override
	////////////////////////////////////////////////////////////

	// Masked bits follow the host, the rest follow board status
	assign o_led = (led_mask & led_state) | (~led_mask & i_led_status);

endmodule

/* logic/audio_mixer.sv */
// One audio channel with deglitch, Linux sum, cross-feed, attenuation and clamp
`timescale 1ns/1ns

module audio_mixer (
	input  logic                    clk_sys,
	input  logic                    resetd,
	input  hal_audio_pkg::sample_t  i_core,
	input  hal_audio_pkg::sample_t  i_linux,
	input  hal_audio_pkg::sample_t  i_pre_in,
	input  logic                    i_signed,
	input  hal_audio_pkg::mix_mode_t i_mix,
	input  hal_cfg_pkg::vol_att_t   i_att,
	output hal_audio_pkg::sample_t  o_pre,
	output hal_audio_pkg::sample_t  o_out
);

	import hal_audio_pkg::*;

	sample_t d1;
	sample_t d2;
	sample_t d3;
	sample_t core_held;
	acc_t    a1;
	acc_t    a2;
	acc_t    a3;
	acc_t    a4;
	acc_t    pre_ext;

	assign pre_ext = {i_pre_in[15], i_pre_in};

	////////////////////////////////////////////////////////////
	// Deglitch
	////////////////////////////////////////////////////////////

	// Held sample moves only once two delayed copies agree
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			d1        <= '0;
			d2        <= '0;
			d3        <= '0;
			core_held <= '0;
		end else begin
			d1 <= i_core;
			d2 <= d1;
			d3 <= d2;
			if (d2 == d3) begin
				core_held <= d2;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Sum, mix, attenuate, clamp
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			a1    <= '0;
			a2    <= '0;
			a3    <= '0;
			a4    <= '0;
			o_pre <= '0;
			o_out <= '0;
		end else begin
			// Unsigned core audio is halved to fit the signed range
			a1 <= i_signed ? {core_held[15], core_held} : {2'b00, core_held[15:1]};
			a2 <= a1 + {i_linux[15], i_linux};

			o_pre <= a2[16:1];

			case (i_mix)
				MIX_NONE: a3 <= a2;
				MIX_25:   a3 <= a2 - (a2 >>> 3) + (pre_ext >>> 2);
				MIX_50:   a3 <= a2 - (a2 >>> 2) + (pre_ext >>> 1);
				MIX_MONO: a3 <= (a2 >>> 1) + pre_ext;
				default:  a3 <= a2;
			endcase

			if (i_att[4]) begin
				a4 <= '0;
			end else begin
				a4 <= a3 >>> i_att[3:0];
			end

			// Top two bits disagree on overflow
			o_out <= ^a4[16:15] ? {a4[16], {15{a4[15]}}} : a4[15:0];
		end
	end

endmodule

/* logic/sync_polarity.sv */
// Sync normaliser that keeps the shorter phase of the input high
`timescale 1ns/1ns

module sync_polarity #(
	parameter int SYNC_CNT_W = 16
) (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	typedef logic [SYNC_CNT_W-1:0] cnt_t;

	logic s1;
	logic s2;
	logic pol;
	cnt_t cnt;
	cnt_t high_len;
	cnt_t low_len;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1       <= 1'b0;
			s2       <= 1'b0;
			cnt      <= '0;
			high_len <= '0;
			low_len  <= '0;
			pol      <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;

			// Rising edge closes a low phase, falling edge a high one
			if (!s2 && s1) begin
				low_len <= cnt;
			end
			if (s2 && !s1) begin
				high_len <= cnt;
			end

			if (s2 != s1) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end

			pol <= (high_len > low_len);
		end
	end

	assign o_sync = i_sync ^ pol;

endmodule

/* logic/sys_hal_top.sv */
// Board support top with HPS registers, stereo mixer and sync normalisers
`timescale 1ns/1ns

module sys_hal_top #(
	parameter int SYNC_CNT_W = 16
) (
	input  logic                       clk_sys,
	input  logic                       resetd,
	input  logic                       i_io_req,
	input  logic                       i_io_uio,
	input  hal_cfg_pkg::io_word_t      i_io_din,
	output logic                       o_io_ack,
	input  hal_cfg_pkg::led_t          i_led_status,
	output hal_cfg_pkg::led_t          o_led,
	input  hal_audio_pkg::audio_pair_t i_core_audio,
	input  hal_audio_pkg::audio_pair_t i_linux_audio,
	input  logic                       i_audio_signed,
	input  hal_audio_pkg::mix_mode_t   i_audio_mix,
	output hal_audio_pkg::audio_pair_t o_audio,
	input  hal_audio_pkg::sync_pair_t  i_sync,
	output hal_audio_pkg::sync_pair_t  o_sync
);

	import hal_cfg_pkg::*;
	import hal_audio_pkg::*;

	vol_att_t vol_att;
	sample_t  pre_l;
	sample_t  pre_r;
	sample_t  out_l;
	sample_t  out_r;
	logic     hs_out;
	logic     vs_out;

	assign o_audio = '{l: out_l, r: out_r};
	assign o_sync  = '{hs: hs_out, vs: vs_out};

	////////////////////////////////////////////////////////////
	// Command port
	////////////////////////////////////////////////////////////

	hps_io_regs u_regs (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_io_req     (i_io_req),
		.i_io_uio     (i_io_uio),
		.i_io_din     (i_io_din),
		.o_io_ack     (o_io_ack),
		.i_led_status (i_led_status),
		.o_led        (o_led),
		.o_vol_att    (vol_att)
	);

	////////////////////////////////////////////////////////////
	// Audio, each side feeds its half sum to the other
	////////////////////////////////////////////////////////////

	audio_mixer u_mix_l (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_core   (i_core_audio.l),
		.i_linux  (i_linux_audio.l),
		.i_pre_in (pre_r),
		.i_signed (i_audio_signed),
		.i_mix    (i_audio_mix),
		.i_att    (vol_att),
		.o_pre    (pre_l),
		.o_out    (out_l)
	);

	audio_mixer u_mix_r (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_core   (i_core_audio.r),
		.i_linux  (i_linux_audio.r),
		.i_pre_in (pre_l),
		.i_signed (i_audio_signed),
		.i_mix    (i_audio_mix),
		.i_att    (vol_att),
		.o_pre    (pre_r),
		.o_out    (out_r)
	);

	// Sync polarity
	sync_polarity #(.SYNC_CNT_W(SYNC_CNT_W)) u_sync_h (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_sync.hs),
		.o_sync  (hs_out)
	);

	sync_polarity #(.SYNC_CNT_W(SYNC_CNT_W)) u_sync_v (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_sync.vs),
		.o_sync  (vs_out)
	);

endmodule

/* verification/sys_hal_sva.sv */
// Handshake and register assertions bound into the HPS command port
`timescale 1ns/1ns

module sys_hal_sva (
	input logic                  clk_sys,
	input logic                  resetd,
	input logic                  i_io_req,
	input logic                  o_io_ack,
	input logic                  io_strobe,
	input hal_cfg_pkg::vol_att_t o_vol_att
);

	// Read by the testbench summary
	int sva_errors = 0;

	////////////////////////////////////////////////////////////
	// Handshake
	////////////////////////////////////////////////////////////

	ack_low_after_reset: assert property (@(posedge clk_sys)
		resetd |=> !o_io_ack)
		else begin
			sva_errors++;
			$error("o_io_ack high after reset");
		end

	// Ack follows req through two register stages
	ack_rise_after_req: assert property (@(posedge clk_sys) disable iff (resetd)
		$rose(o_io_ack) |-> $past(i_io_req, 2))
		else begin
			sva_errors++;
			$error("o_io_ack rose without i_io_req two cycles before");
		end

	ack_fall_after_req: assert property (@(posedge clk_sys) disable iff (resetd)
		$fell(o_io_ack) |-> !$past(i_io_req, 2))
		else begin
			sva_errors++;
			$error("o_io_ack fell while i_io_req was still high");
		end

	// Register writes only on a word strobe
	vol_stable_no_strobe: assert property (@(posedge clk_sys) disable iff (resetd)
		!io_strobe |=> $stable(o_vol_att))
		else begin
			sva_errors++;
			$error("o_vol_att changed without a word strobe");
		end

endmodule

bind hps_io_regs sys_hal_sva u_sva (
	.clk_sys   (clk_sys),
	.resetd    (resetd),
	.i_io_req  (i_io_req),
	.o_io_ack  (o_io_ack),
	.io_strobe (io_strobe),
	.o_vol_att (o_vol_att)
);

/* verification/tb_sys_hal.sv */
// Directed testbench for the HPS port, stereo mixer and sync normalisers
`timescale 1ns/1ns

module tb_sys_hal;

	import hal_cfg_pkg::*;
	import hal_audio_pkg::*;

	localparam int          HS_TIMEOUT    = 20;
	localparam int          AUDIO_TIMEOUT = 64;
	localparam int          SYNC_PERIOD   = 16;
	localparam int unsigned RAND_SEED     = 32'hafcda66c;

	logic        clk_sys;
	logic        resetd;
	logic        io_req;
	logic        io_uio;
	io_word_t    io_din;
	logic        io_ack;
	led_t        led_status;
	led_t        led_out;
	audio_pair_t core_audio;
	audio_pair_t linux_audio;
	logic        audio_signed;
	mix_mode_t   audio_mix;
	audio_pair_t audio_out;
	sync_pair_t  sync_in;
	sync_pair_t  sync_out;

	int errors;
	int checks;
	int tests;

	sys_hal_top #(.SYNC_CNT_W(16)) u_dut (
		.clk_sys        (clk_sys),
		.resetd         (resetd),
		.i_io_req       (io_req),
		.i_io_uio       (io_uio),
		.i_io_din       (io_din),
		.o_io_ack       (io_ack),
		.i_led_status   (led_status),
		.o_led          (led_out),
		.i_core_audio   (core_audio),
		.i_linux_audio  (linux_audio),
		.i_audio_signed (audio_signed),
		.i_audio_mix    (audio_mix),
		.o_audio        (audio_out),
		.i_sync         (sync_in),
		.o_sync         (sync_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_led(input string name, input led_t exp, input led_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
		end
	endtask

	task automatic check_sample(input string name, input sample_t exp, input sample_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests++;
		$display("Test %s done, %0d errors", name, errors - errors_before);
	endtask

	////////////////////////////////////////////////////////////
	// Expected values
	////////////////////////////////////////////////////////////

	// Per bit, the override state wins where the mask is set
	function automatic led_t led_expect(input led_t mask, input led_t state, input led_t status);
		led_t r;
		for (int i = 0; i < 8; i++) begin
			r[i] = mask[i] ? state[i] : status[i];
		end
		return r;
	endfunction

	function automatic sample_t clamp_sample(input int v);
		if (v > 32767) return 16'h7fff;
		if (v < -32768) return 16'h8000;
		return sample_t'(v);
	endfunction

	// Core sample scaled by signedness plus the Linux sample
	function automatic int sum_stage(input sample_t core, input sample_t lin, input logic sgn);
		int base;
		if (sgn) begin
			base = int'($signed(core));
		end else begin
			base = int'(core[15:1]);
		end
		return base + int'($signed(lin));
	endfunction

	function automatic sample_t mix_expect(input sample_t core_s, input sample_t lin_s,
			input sample_t core_o, input sample_t lin_o, input logic sgn,
			input mix_mode_t mode, input vol_att_t att);
		int own;
		int pre;
		int mixed;
		own = sum_stage(core_s, lin_s, sgn);
		pre = sum_stage(core_o, lin_o, sgn) >>> 1;
		case (mode)
			MIX_25:   mixed = own - (own >>> 3) + (pre >>> 2);
			MIX_50:   mixed = own - (own >>> 2) + (pre >>> 1);
			MIX_MONO: mixed = (own >>> 1) + pre;
			default:  mixed = own;
		endcase
		if (att[4]) begin
			mixed = 0;
		end else begin
			mixed = mixed >>> att[3:0];
		end
		return clamp_sample(mixed);
	endfunction

	function automatic sample_t shift_expect(input sample_t core, input vol_att_t att);
		if (att[4]) return '0;
		return sample_t'(int'($signed(core)) >>> att[3:0]);
	endfunction

	////////////////////////////////////////////////////////////
	// Drivers
	////////////////////////////////////////////////////////////

	// One four-phase req/ack transfer
	task automatic host_write(input logic uio, input io_word_t word);
		int cycles;
		@(posedge clk_sys);
		io_uio <= uio;
		io_din <= word;
		io_req <= 1'b1;
		cycles = 0;
		@(negedge clk_sys);
		while (!io_ack && cycles < HS_TIMEOUT) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (!io_ack) begin
			errors++;
			$display("Timeout waiting for o_io_ack to rise while i_io_req was high");
		end
		@(posedge clk_sys);
		io_req <= 1'b0;
		cycles = 0;
		@(negedge clk_sys);
		// Ack holds until the dropped req has passed both stages
		check_bit("o_io_ack", 1'b1, io_ack);
		while (io_ack && cycles < HS_TIMEOUT) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (io_ack) begin
			errors++;
			$display("Timeout waiting for o_io_ack to fall after i_io_req dropped");
		end
	endtask

	task automatic close_frame();
		@(posedge clk_sys);
		io_uio <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic send_command(input cmd_t cmd, input io_word_t data);
		host_write(1'b1, {8'h00, cmd});
		host_write(1'b1, data);
		close_frame();
	endtask

	task automatic set_audio(input sample_t cl, input sample_t cr, input sample_t ll,
			input sample_t lr, input logic sgn, input mix_mode_t mode);
		@(posedge clk_sys);
		core_audio.l  <= cl;
		core_audio.r  <= cr;
		linux_audio.l <= ll;
		linux_audio.r <= lr;
		audio_signed  <= sgn;
		audio_mix     <= mode;
	endtask

	// Both channels must hold the expected value for four samples
	task automatic wait_audio(input sample_t exp_l, input sample_t exp_r);
		int stable;
		int cycles;
		stable = 0;
		cycles = 0;
		while (stable < 4 && cycles < AUDIO_TIMEOUT) begin
			@(negedge clk_sys);
			cycles++;
			if (audio_out.l == exp_l && audio_out.r == exp_r) begin
				stable++;
			end else begin
				stable = 0;
			end
		end
		if (stable < 4) begin
			errors++;
			$display("Audio output did not settle within %0d cycles", AUDIO_TIMEOUT);
			check_sample("o_audio.l", exp_l, audio_out.l);
			check_sample("o_audio.r", exp_r, audio_out.r);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic test_after_reset();
		int e0;
		e0 = errors;
		@(negedge clk_sys);
		check_bit("o_io_ack", 1'b0, io_ack);
		check_led("o_led", led_status, led_out);
		finish_test("after_reset", e0);
	endtask

	// Words outside a frame complete the handshake but change nothing
	task automatic test_handshake();
		int e0;
		e0 = errors;
		host_write(1'b0, {8'h00, CMD_LED});
		host_write(1'b0, 16'hffff);
		for (int i = 0; i < 4; i++) begin
			host_write(1'b0, io_word_t'($urandom));
		end
		check_led("o_led", led_status, led_out);
		finish_test("handshake", e0);
	endtask

	task automatic test_led_override();
		int   e0;
		led_t mask;
		led_t state;
		led_t status;
		e0 = errors;
		mask = led_t'($urandom);
		state = led_t'($urandom);
		send_command(CMD_LED, {mask, state});
		@(negedge clk_sys);
		check_led("o_led", led_expect(mask, state, led_status), led_out);

		// Unmasked bits follow the board status
		status = led_t'($urandom);
		@(posedge clk_sys);
		led_status <= status;
		@(negedge clk_sys);
		check_led("o_led", led_expect(mask, state, status), led_out);

		// Frame restart turns the next word into a command
		host_write(1'b1, {8'h00, CMD_LED});
		close_frame();
		host_write(1'b1, io_word_t'($urandom));
		close_frame();
		@(negedge clk_sys);
		check_led("o_led", led_expect(mask, state, status), led_out);

		send_command(8'h3c, io_word_t'($urandom));
		@(negedge clk_sys);
		check_led("o_led", led_expect(mask, state, status), led_out);
		finish_test("led_override", e0);
	endtask

	task automatic test_volume();
		int       e0;
		vol_att_t att;
		sample_t  cl;
		sample_t  cr;
		e0 = errors;
		for (int i = 0; i < 8; i++) begin
			if (i < 6) begin
				att = vol_att_t'($urandom_range(15, 0));
			end else begin
				att = vol_att_t'($urandom_range(31, 16));
			end
			cl = sample_t'($urandom);
			cr = sample_t'($urandom);
			send_command(CMD_VOL, {11'h000, att});
			set_audio(cl, cr, '0, '0, 1'b1, MIX_NONE);
			wait_audio(shift_expect(cl, att), shift_expect(cr, att));
		end
		finish_test("volume", e0);
	endtask

	task automatic test_mixing();
		int        e0;
		mix_mode_t mode;
		sample_t   cl;
		sample_t   cr;
		sample_t   ll;
		sample_t   lr;
		e0 = errors;
		send_command(CMD_VOL, 16'h0000);
		for (int m = 0; m < 4; m++) begin
			mode = mix_mode_t'(m);
			for (int s = 0; s < 2; s++) begin
				for (int k = 0; k < 2; k++) begin
					cl = sample_t'($urandom);
					cr = sample_t'($urandom);
					ll = sample_t'($urandom);
					lr = sample_t'($urandom);
					set_audio(cl, cr, ll, lr, s[0], mode);
					wait_audio(mix_expect(cl, ll, cr, lr, s[0], mode, 5'd0),
						mix_expect(cr, lr, cl, ll, s[0], mode, 5'd0));
				end
			end
			// Near full scale drives the clamp
			set_audio(16'h7ff0, 16'h8010, 16'h7f00, 16'h8100, 1'b1, mode);
			wait_audio(mix_expect(16'h7ff0, 16'h7f00, 16'h8010, 16'h8100, 1'b1, mode, 5'd0),
				mix_expect(16'h8010, 16'h8100, 16'h7ff0, 16'h7f00, 1'b1, mode, 5'd0));
		end
		finish_test("mixing", e0);
	endtask

	// Hsync has a short low phase, vsync a short high phase
	task automatic test_sync_polarity();
		int   e0;
		logic hs_v;
		logic vs_v;
		e0 = errors;
		for (int t = 0; t < 6 * SYNC_PERIOD; t++) begin
			hs_v = (t % SYNC_PERIOD) < 12;
			vs_v = (t % SYNC_PERIOD) < 4;
			@(posedge clk_sys);
			sync_in.hs <= hs_v;
			sync_in.vs <= vs_v;
			@(negedge clk_sys);
			if (t >= 3 * SYNC_PERIOD) begin
				check_bit("o_sync.hs", ~hs_v, sync_out.hs);
				check_bit("o_sync.vs", vs_v, sync_out.vs);
			end
		end
		finish_test("sync_polarity", e0);
	endtask

	////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////

	initial begin
		errors = 0;
		checks = 0;
		tests = 0;
		void'($urandom(RAND_SEED));
		resetd       <= 1'b1;
		io_req       <= 1'b0;
		io_uio       <= 1'b0;
		io_din       <= '0;
		led_status   <= led_t'($urandom);
		core_audio   <= '0;
		linux_audio  <= '0;
		audio_signed <= 1'b1;
		audio_mix    <= MIX_NONE;
		sync_in      <= '0;
		repeat (4) @(posedge clk_sys);
		resetd <= 1'b0;

		test_after_reset();
		test_handshake();
		test_led_override();
		test_volume();
		test_mixing();
		test_sync_polarity();

		errors += u_dut.u_regs.u_sva.sva_errors;
		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* sys_hal_top.f */
logic/hal_cfg_pkg.sv
logic/hal_audio_pkg.sv
logic/hps_io_regs.sv
logic/audio_mixer.sv
logic/sync_polarity.sv
logic/sys_hal_top.sv
verification/sys_hal_sva.sv
verification/tb_sys_hal.sv

/* Makefile */
# Verilator build and run for the board support layer

VERILATOR ?= verilator
TOP       ?= tb_sys_hal
FILELIST  ?= sys_hal_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= TEST RESULT: PASS

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
